// File: Makefile
.PHONY: all run lint clean

all: run

obj_dir/core_sim: sources.f
	verilator --binary --assert --top-module core_tb -f sources.f -o core_sim

run: obj_dir/core_sim
	./obj_dir/core_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only --timing --top-module core_tb -f sources.f

clean:
	rm -rf obj_dir sim.log

// File: include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data and address width.
`define CORE_DATA_W 32

// Architectural registers, R15 is the pc.
`define CORE_REG_COUNT 16

// R15 reads ahead of the executing pc.
`define CORE_PC_AHEAD 8

`endif

// File: rtl/alu_execute.sv
`default_nettype none

`include "core_settings.svh"

module alu_execute (
	input  logic                clk,
	input  logic                rst,
	input  core_pkg::dec_op_t   dec_op,
	output core_pkg::exec_res_t exec_res,
	output core_pkg::fwd_t      exec_fwd,
	output logic                jmp,
	output core_pkg::word_t     jmppc
);
	import core_pkg::*;

	flags_t flags_q;
	flags_t flags_nx;
	flags_t alu_flags;
	logic   cond_ok;
	logic   logical;
	logic   wr_ok;
	word_t  add_a;
	word_t  add_b;
	logic   add_cin;
	logic [`CORE_DATA_W:0] sum;
	word_t  result;

	function automatic logic cond_pass(cond_e cc, flags_t f);
		case (cc)
			COND_EQ: cond_pass = f.z;
			COND_NE: cond_pass = !f.z;
			COND_CS: cond_pass = f.c;
			COND_CC: cond_pass = !f.c;
			COND_MI: cond_pass = f.n;
			COND_PL: cond_pass = !f.n;
			COND_VS: cond_pass = f.v;
			COND_VC: cond_pass = !f.v;
			COND_HI: cond_pass = f.c && !f.z;
			COND_LS: cond_pass = !f.c || f.z;
			COND_GE: cond_pass = (f.n == f.v);
			COND_LT: cond_pass = (f.n != f.v);
			COND_GT: cond_pass = !f.z && (f.n == f.v);
			COND_LE: cond_pass = f.z || (f.n != f.v);
			COND_AL: cond_pass = 1'b1;
			default: cond_pass = 1'b0; // NV never executes.
		endcase
	endfunction

	assign cond_ok = cond_pass(dec_op.cond, flags_q);

	// ========================================
	// Adder operand steering
	// ========================================

	always_comb
	begin
		add_a   = dec_op.op_a;
		add_b   = dec_op.op_b;
		add_cin = 1'b0;
		case (dec_op.alu_op)
			ALU_SUB, ALU_CMP:
			begin
				add_b   = ~dec_op.op_b;
				add_cin = 1'b1;
			end
			ALU_RSB:
			begin
				add_a   = dec_op.op_b;
				add_b   = ~dec_op.op_a;
				add_cin = 1'b1;
			end
			ALU_ADC: add_cin = flags_q.c;
			ALU_SBC:
			begin
				add_b   = ~dec_op.op_b;
				add_cin = flags_q.c;
			end
			ALU_RSC:
			begin
				add_a   = dec_op.op_b;
				add_b   = ~dec_op.op_a;
				add_cin = flags_q.c;
			end
			default:
			begin
			end
		endcase
	end

	assign sum = {1'b0, add_a} + {1'b0, add_b} + {{`CORE_DATA_W{1'b0}}, add_cin};

	always_comb
	begin
		logical = 1'b1;
		case (dec_op.alu_op)
			ALU_AND, ALU_TST: result = dec_op.op_a & dec_op.op_b;
			ALU_EOR, ALU_TEQ: result = dec_op.op_a ^ dec_op.op_b;
			ALU_ORR: result = dec_op.op_a | dec_op.op_b;
			ALU_MOV: result = dec_op.op_b;
			ALU_BIC: result = dec_op.op_a & ~dec_op.op_b;
			ALU_MVN: result = ~dec_op.op_b;
			default:
			begin
				result  = sum[`CORE_DATA_W-1:0];
				logical = 1'b0;
			end
		endcase

		alu_flags.n = result[`CORE_DATA_W-1];
		alu_flags.z = (result == '0);
		if (logical)
		begin
			// Carry from the immediate rotate only.
			alu_flags.c = dec_op.rot_valid ? dec_op.rot_carry : flags_q.c;
			alu_flags.v = flags_q.v;
		end
		else
		begin
			alu_flags.c = sum[`CORE_DATA_W];
			alu_flags.v = (add_a[`CORE_DATA_W-1] == add_b[`CORE_DATA_W-1])
				&& (result[`CORE_DATA_W-1] != add_a[`CORE_DATA_W-1]);
		end
	end

	assign flags_nx = (dec_op.valid && cond_ok && dec_op.set_flags) ? alu_flags : flags_q;
	assign wr_ok    = dec_op.valid && cond_ok && dec_op.write_en;

	assign exec_fwd = '{valid: wr_ok, rd: dec_op.rd, data: result};

	// Branch resolves here and kills the decode slot.
	assign jmp   = dec_op.valid && dec_op.is_branch && cond_ok;
	assign jmppc = dec_op.pc + `CORE_PC_AHEAD
		+ {{(`CORE_DATA_W-26){dec_op.br_offset[23]}}, dec_op.br_offset, 2'b00};

	always_ff @(posedge clk)
	begin
		if (rst)
			flags_q <= '0;
		else
			flags_q <= flags_nx;
	end

	always_ff @(posedge clk)
	begin
		exec_res.rd    <= dec_op.rd;
		exec_res.data  <= result;
		exec_res.flags <= flags_nx;
		if (rst)
		begin
			exec_res.valid    <= 1'b0;
			exec_res.write_en <= 1'b0;
		end
		else
		begin
			exec_res.valid    <= dec_op.valid;
			exec_res.write_en <= wr_ok;
		end
	end

endmodule

`default_nettype wire

// File: rtl/core_pkg.sv
`default_nettype none

`include "core_settings.svh"

package core_pkg;

	typedef logic [`CORE_DATA_W-1:0] word_t;
	typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_addr_t;

	// Data-processing opcodes, ARM numbering.
	typedef enum logic [3:0] {
		ALU_AND = 4'h0,
		ALU_EOR = 4'h1,
		ALU_SUB = 4'h2,
		ALU_RSB = 4'h3,
		ALU_ADD = 4'h4,
		ALU_ADC = 4'h5,
		ALU_SBC = 4'h6,
		ALU_RSC = 4'h7,
		ALU_TST = 4'h8,
		ALU_TEQ = 4'h9,
		ALU_CMP = 4'hA,
		ALU_CMN = 4'hB,
		ALU_ORR = 4'hC,
		ALU_MOV = 4'hD,
		ALU_BIC = 4'hE,
		ALU_MVN = 4'hF
	} alu_op_e;

	typedef enum logic [3:0] {
		COND_EQ, COND_NE, COND_CS, COND_CC,
		COND_MI, COND_PL, COND_VS, COND_VC,
		COND_HI, COND_LS, COND_GE, COND_LT,
		COND_GT, COND_LE, COND_AL, COND_NV
	} cond_e;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flags_t;

	// Fetch side input.
	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t insn;
	} insn_in_t;

	// ========================================
	// Stage bundles
	// ========================================

	typedef struct packed {
		logic        valid;
		word_t       pc;
		cond_e       cond;
		logic        is_branch;
		logic [23:0] br_offset; // Signed word offset.
		alu_op_e     alu_op;
		logic        set_flags;
		logic        write_en;
		reg_addr_t   rd;
		word_t       op_a;
		word_t       op_b;
		logic        rot_valid; // Rotate amount was nonzero.
		logic        rot_carry;
	} dec_op_t;

	typedef struct packed {
		logic      valid;
		logic      write_en;
		reg_addr_t rd;
		word_t     data;
		flags_t    flags;
	} exec_res_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     data;
	} fwd_t;

	typedef struct packed {
		logic      valid;
		logic      write_en;
		reg_addr_t rd;
		word_t     data;
		flags_t    flags;
	} retire_t;

endpackage

`default_nettype wire

// File: rtl/core_top.sv
`default_nettype none

`include "core_settings.svh"

module core_top (
	input  logic                    clk,
	input  logic                    rst,
	input  core_pkg::insn_in_t      insn_in,
	output core_pkg::retire_t       retire,
	output logic                    jmp,
	output logic [`CORE_DATA_W-1:0] jmppc
);
	import core_pkg::*;

	dec_op_t   dec_op;
	exec_res_t exec_res;
	fwd_t      exec_fwd;
	fwd_t      wb_fwd;
	reg_addr_t rd_addr_a;
	reg_addr_t rd_addr_b;
	word_t     rd_data_a;
	word_t     rd_data_b;
	logic      wr_en;
	reg_addr_t wr_addr;
	word_t     wr_data;

	insn_decode decode_i (
		.clk(clk), .rst(rst),
		.insn_in(insn_in), .flush(jmp), // Taken branch squashes decode.
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.exec_fwd(exec_fwd), .wb_fwd(wb_fwd),
		.dec_op(dec_op));

	alu_execute execute_i (
		.clk(clk), .rst(rst),
		.dec_op(dec_op), .exec_res(exec_res), .exec_fwd(exec_fwd),
		.jmp(jmp), .jmppc(jmppc));

	result_writeback result_i (
		.clk(clk), .rst(rst),
		.exec_res(exec_res),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.wb_fwd(wb_fwd), .retire(retire));

	reg_file regfile_i (
		.clk(clk), .rst(rst),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data));

endmodule

`default_nettype wire

// File: rtl/insn_decode.sv
`default_nettype none

`include "core_settings.svh"

module insn_decode (
	input  logic                clk,
	input  logic                rst,
	input  core_pkg::insn_in_t  insn_in,
	input  logic                flush,
	output core_pkg::reg_addr_t rd_addr_a,
	output core_pkg::reg_addr_t rd_addr_b,
	input  core_pkg::word_t     rd_data_a,
	input  core_pkg::word_t     rd_data_b,
	input  core_pkg::fwd_t      exec_fwd,
	input  core_pkg::fwd_t      wb_fwd,
	output core_pkg::dec_op_t   dec_op
);
	import core_pkg::*;

	localparam reg_addr_t PC_REG = reg_addr_t'(`CORE_REG_COUNT - 1);

	word_t     insn;
	word_t     pc_ahead;
	alu_op_e   opcode;
	logic      imm_form;
	logic      set_bit;
	logic      is_test;
	logic      is_dp;
	logic      is_branch;
	reg_addr_t rn;
	reg_addr_t rd;
	reg_addr_t rm;
	logic [3:0] rot;
	logic [2*`CORE_DATA_W-1:0] imm_pair;
	word_t     imm_val;
	dec_op_t   dec_next;

	// Newest producer wins, R15 is never written.
	function automatic word_t operand(reg_addr_t addr, word_t rf_data, fwd_t ef, fwd_t wf,
			word_t pc_val);
		if (addr == PC_REG)
			return pc_val;
		else if (ef.valid && ef.rd == addr)
			return ef.data;
		else if (wf.valid && wf.rd == addr)
			return wf.data;
		else
			return rf_data;
	endfunction

	// ========================================
	// Field extraction
	// ========================================

	assign insn     = insn_in.insn;
	assign pc_ahead = insn_in.pc + `CORE_PC_AHEAD;
	assign opcode   = alu_op_e'(insn[24:21]);
	assign imm_form = insn[25];
	assign set_bit  = insn[20];
	assign rn       = insn[19:16];
	assign rd       = insn[15:12];
	assign rm       = insn[3:0];
	assign rot      = insn[11:8];

	assign is_test   = (insn[24:23] == 2'b10); // TST, TEQ, CMP, CMN.
	assign is_dp     = (insn[27:26] == 2'b00) && (imm_form || insn[11:4] == 8'h00)
		&& !(is_test && !set_bit);
	assign is_branch = (insn[27:25] == 3'b101);

	// Rotate right by twice the field.
	assign imm_pair = {2{{(`CORE_DATA_W-8){1'b0}}, insn[7:0]}} >> {rot, 1'b0};
	assign imm_val  = imm_pair[`CORE_DATA_W-1:0];

	assign rd_addr_a = rn;
	assign rd_addr_b = rm;

	always_comb
	begin
		dec_next.valid     = insn_in.valid;
		dec_next.pc        = insn_in.pc;
		dec_next.cond      = cond_e'(insn[31:28]);
		dec_next.is_branch = is_branch;
		dec_next.br_offset = insn[23:0];
		dec_next.alu_op    = opcode;
		dec_next.set_flags = is_dp && set_bit;
		dec_next.write_en  = is_dp && !is_test && rd != PC_REG; // Unknown encodings never write.
		dec_next.rd        = rd;
		dec_next.op_a      = operand(rn, rd_data_a, exec_fwd, wb_fwd, pc_ahead);
		dec_next.op_b      = imm_form ? imm_val
			: operand(rm, rd_data_b, exec_fwd, wb_fwd, pc_ahead);
		dec_next.rot_valid = imm_form && rot != 4'd0;
		dec_next.rot_carry = imm_val[`CORE_DATA_W-1];
	end

	always_ff @(posedge clk)
	begin
		dec_op <= dec_next;
		if (rst || flush)
			dec_op.valid <= 1'b0;
	end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`default_nettype none

`include "core_settings.svh"

module reg_file (
	input  logic                clk,
	input  logic                rst,
	input  core_pkg::reg_addr_t rd_addr_a,
	input  core_pkg::reg_addr_t rd_addr_b,
	output core_pkg::word_t     rd_data_a,
	output core_pkg::word_t     rd_data_b,
	input  logic                wr_en,
	input  core_pkg::reg_addr_t wr_addr,
	input  core_pkg::word_t     wr_data
);
	import core_pkg::*;

	word_t regs [`CORE_REG_COUNT];

	always_ff @(posedge clk)
	begin
		if (rst)
			regs <= '{default: '0};
		else if (wr_en)
			regs[wr_addr] <= wr_data;
	end

	// Write-through so a reader in the write cycle sees new data.
	assign rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
	assign rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

`default_nettype wire

// File: rtl/result_writeback.sv
`default_nettype none

module result_writeback (
	input  logic                clk,
	input  logic                rst,
	input  core_pkg::exec_res_t exec_res,
	output logic                wr_en,
	output core_pkg::reg_addr_t wr_addr,
	output core_pkg::word_t     wr_data,
	output core_pkg::fwd_t      wb_fwd,
	output core_pkg::retire_t   retire
);
	assign wr_en   = exec_res.valid && exec_res.write_en;
	assign wr_addr = exec_res.rd;
	assign wr_data = exec_res.data;

	assign wb_fwd = '{valid: wr_en, rd: exec_res.rd, data: exec_res.data}; // Same as port.

	always_ff @(posedge clk)
	begin
		retire.rd    <= exec_res.rd;
		retire.data  <= exec_res.data;
		retire.flags <= exec_res.flags;
		if (rst)
		begin
			retire.valid    <= 1'b0;
			retire.write_en <= 1'b0;
		end
		else
		begin
			retire.valid    <= exec_res.valid;
			retire.write_en <= exec_res.write_en;
		end
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
rtl/core_pkg.sv
rtl/reg_file.sv
rtl/insn_decode.sv
rtl/alu_execute.sv
rtl/result_writeback.sv
rtl/core_top.sv
verif/core_props.sv
verif/core_checker.sv
verif/core_tb.sv

// File: verif/core_checker.sv
`default_nettype none

`include "core_settings.svh"

module core_checker (
	input  logic                    clk,
	input  logic                    rst,
	input  core_pkg::insn_in_t      insn_in,
	input  core_pkg::retire_t       retire,
	input  logic                    jmp,
	input  logic [`CORE_DATA_W-1:0] jmppc
);
	import core_pkg::*;

	retire_t    exp_retire[$];
	word_t      exp_jump[$];
	logic [2:0] live_hist = '0; // Inputs in flight, oldest in bit 2.
	int         errors = 0;
	int         checks = 0;

	task automatic expect_retire(input logic we, input reg_addr_t rd, input word_t data,
			input flags_t flags);
		retire_t rec;
		rec.valid    = 1'b1;
		rec.write_en = we;
		rec.rd       = rd;
		rec.data     = data;
		rec.flags    = flags;
		exp_retire.push_back(rec);
	endtask

	task automatic expect_jump(input word_t pc);
		exp_jump.push_back(pc);
	endtask

	function automatic int pending_count();
		return exp_retire.size() + exp_jump.size();
	endfunction

	task automatic report_leftover();
		if (exp_retire.size() != 0)
		begin
			$display("%0d expected retire records never arrived", exp_retire.size());
			errors += exp_retire.size();
		end
		if (exp_jump.size() != 0)
		begin
			$display("%0d expected jumps never arrived", exp_jump.size());
			errors += exp_jump.size();
		end
	endtask

	task automatic mismatch(input string name, input word_t exp, input word_t act);
		$display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
		errors++;
	endtask

	// ========================================
	// Compare at mid-cycle while outputs are stable.
	// ========================================

	always @(negedge clk)
	begin
		retire_t exp;
		if (!rst && retire.valid)
		begin
			checks++;
			if (exp_retire.size() == 0)
			begin
				$display("Retire at t=%0t with no expected record", $time);
				errors++;
			end
			else
			begin
				exp = exp_retire.pop_front();
				if (retire.write_en !== exp.write_en)
					mismatch("retire.write_en", word_t'(exp.write_en), word_t'(retire.write_en));
				if (exp.write_en && retire.rd !== exp.rd)
					mismatch("retire.rd", word_t'(exp.rd), word_t'(retire.rd));
				if (exp.write_en && retire.data !== exp.data)
					mismatch("retire.data", exp.data, retire.data);
				if (retire.flags !== exp.flags)
					mismatch("retire.flags", word_t'(exp.flags), word_t'(retire.flags));
			end
		end
		if (!rst && jmp)
		begin
			checks++;
			if (exp_jump.size() == 0)
			begin
				$display("Jump at t=%0t with no expected record", $time);
				errors++;
			end
			else if (jmppc !== exp_jump[0])
				mismatch("jmppc", exp_jump.pop_front(), jmppc);
			else
				void'(exp_jump.pop_front());
		end
	end

	// Retire follows input by 3 cycles unless a taken branch squashed it.
	always @(negedge clk)
	begin
		if (rst !== 1'b0)
			live_hist = '0;
		else
		begin
			if (retire.valid !== live_hist[2])
				mismatch("retire.valid", word_t'(live_hist[2]), word_t'(retire.valid));
			live_hist = {live_hist[1:0], insn_in.valid && !jmp};
		end
	end

endmodule

`default_nettype wire

// File: verif/core_input.txt
# I pc insn | G idle | R write_en rd data flags(nzcv) | J jmppc
I 00000000 E3A01005
I 00000004 E3A024FF
I 00000008 E2813010
I 0000000C E0834001
I 00000010 E3510005
I 00000014 13A05001
I 00000018 03A05002
I 0000001C E0926002
I 00000020 E2A17000
I 00000024 E2C18001
G
I 00000028 E3A0A101
I 0000002C E09AB00A
I 00000030 E2129102
I 00000034 E211C004
I 00000038 E1A0000F
I 0000003C E28F1000
I 00000040 E7000000
I 00000044 EA000002
I 00000048 E3A0D099
I 00000054 E28D2001
I 00000058 E3A0F000
I 0000005C E0823002
R 1 1 00000005 0
R 1 2 FF000000 0
R 1 3 00000015 0
R 1 4 0000001A 0
R 0 0 00000000 6
R 0 0 00000000 6
R 1 5 00000002 6
R 1 6 FE000000 A
R 1 7 00000006 A
R 1 8 00000004 A
R 1 10 40000000 A
R 1 11 80000000 9
R 1 9 80000000 B
R 1 12 00000004 3
R 1 0 00000040 3
R 1 1 00000044 3
R 0 0 00000000 3
R 0 0 00000000 3
R 1 2 00000001 3
R 0 0 00000000 3
R 1 3 00000002 3
J 00000054

// File: verif/core_props.sv
`default_nettype none

module core_props (
	input  logic              clk,
	input  logic              rst,
	input  logic              dec_valid,
	input  logic              exec_valid,
	input  core_pkg::retire_t retire,
	input  logic              jmp
);
	import core_pkg::*;

	// A branch kills the next slot, so no back-to-back jumps.
	assert property (@(posedge clk) disable iff (rst) jmp |=> !jmp)
		else $error("jmp high for two cycles in a row");

	assert property (@(posedge clk) rst |=> !dec_valid && !exec_valid && !retire.valid && !jmp)
		else $error("pipeline valid while in reset");

	assert property (@(posedge clk) disable iff (rst)
		!(retire.valid && retire.write_en && retire.rd == 4'd15))
		else $error("retire writes R15");

endmodule

bind core_top core_props props_i (
	.clk(clk),
	.rst(rst),
	.dec_valid(dec_op.valid),
	.exec_valid(exec_res.valid),
	.retire(retire),
	.jmp(jmp)
);

`default_nettype wire

// File: include/core_tb_settings.svh
`ifndef CORE_TB_SETTINGS_SVH
`define CORE_TB_SETTINGS_SVH

// Clock cycles allowed for the pipeline to drain.
`define TB_DRAIN_CYCLES 50

// Reset length in clock cycles.
`define TB_RESET_CYCLES 8

`endif

// File: verif/core_tb.sv
`default_nettype none

`include "core_settings.svh"
`include "core_tb_settings.svh"

module core_tb;
	import core_pkg::*;

	logic     clk;
	logic     rst;
	insn_in_t insn_in;
	retire_t  retire;
	logic     jmp;
	logic [`CORE_DATA_W-1:0] jmppc;

	insn_in_t stim[$];
	int       tb_errors = 0;

	core_top dut_i (
		.clk(clk),
		.rst(rst),
		.insn_in(insn_in),
		.retire(retire),
		.jmp(jmp),
		.jmppc(jmppc)
	);

	core_checker chk_i (
		.clk(clk),
		.rst(rst),
		.insn_in(insn_in),
		.retire(retire),
		.jmp(jmp),
		.jmppc(jmppc)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

	// ========================================
	// Input file parsing
	// ========================================

	task automatic load_input();
		int       fd;
		int       we;
		int       rd;
		string    line;
		byte      kind;
		word_t    a;
		word_t    b;
		logic [3:0] fl;
		insn_in_t item;
		fd = $fopen("verif/core_input.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open verif/core_input.txt");
			tb_errors++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0)
				continue;
			kind = line.getc(0);
			case (kind)
				"I":
				begin
					void'($sscanf(line, "I %h %h", a, b));
					item = '{valid: 1'b1, pc: a, insn: b};
					stim.push_back(item);
				end
				"G": stim.push_back('0); // Idle cycle.
				"R":
				begin
					void'($sscanf(line, "R %d %d %h %h", we, rd, a, fl));
					chk_i.expect_retire(we[0], reg_addr_t'(rd), a, flags_t'(fl));
				end
				"J":
				begin
					void'($sscanf(line, "J %h", a));
					chk_i.expect_jump(a);
				end
				default:
				begin
				end
			endcase
		end
		$fclose(fd);
	endtask

	task automatic drive_stream();
		while (stim.size() != 0)
		begin
			@(posedge clk);
			#1 insn_in = stim.pop_front();
		end
		@(posedge clk);
		#1 insn_in = '0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (chk_i.pending_count() != 0 && cycles < `TB_DRAIN_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		if (chk_i.pending_count() != 0)
		begin
			$display("Timeout waiting for the pipeline to drain");
			tb_errors++;
		end
		repeat (4) @(posedge clk); // Catch stray retires.
	endtask

	initial
	begin
		int total;
		rst     = 1'b1;
		insn_in = '0;
		load_input();
		repeat (`TB_RESET_CYCLES) @(posedge clk);
		#1 rst = 1'b0;
		drive_stream();
		wait_drain();
		chk_i.report_leftover();
		total = tb_errors + chk_i.errors;
		$display("Checks: %0d, errors: %0d (compare %0d, other %0d)",
			chk_i.checks, total, chk_i.errors, tb_errors);
		if (total == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
